/* rtl/uarc_irq_macros.svh */
`ifndef UARC_IRQ_MACROS_SVH
`define UARC_IRQ_MACROS_SVH

// Number of receiver buses served by the interrupt unit
`define UARC_TOTAL_BUSES 8

// Width of the data word carried on each bus
`define UARC_WORD_WIDTH 32

// Width of a handler address in program memory
`define UARC_PROG_ADDR_WIDTH 12

// Register map, in word addresses
`define UARC_REG_SEL 0
`define UARC_REG_EN 1
// Handler address n sits at UARC_REG_ADDR_BASE + n
`define UARC_REG_ADDR_BASE 2

`define UARC_WB_ADDR_WIDTH 4

`endif

/* rtl/uarc_irq_pkg.sv */
`include "uarc_irq_macros.svh"

package uarc_irq_pkg;

  // One data word as carried by a receiver bus
  typedef logic [`UARC_WORD_WIDTH-1:0] word_t;

  // One bit per receiver bus, bit n belongs to bus n
  typedef logic [`UARC_TOTAL_BUSES-1:0] bus_mask_t;

  // Index of a single bus
  typedef logic [$clog2(`UARC_TOTAL_BUSES)-1:0] bus_index_t;

  // Entry point of an interrupt handler
  typedef logic [`UARC_PROG_ADDR_WIDTH-1:0] prog_addr_t;

  // Handler address for every bus, indexed by bus number
  typedef prog_addr_t [`UARC_TOTAL_BUSES-1:0] addr_table_t;

endpackage

/* rtl/irq_choice_if.sv */
`timescale 1ns/1ps

// Carries the chosen interrupt from the arbiter to the dispatcher.
// The choice stays stable from the rise of valid until take is seen with valid
// high, and valid is low in the cycle after that
interface irq_choice_if;

  logic                     valid;
  uarc_irq_pkg::bus_index_t bus;
  uarc_irq_pkg::prog_addr_t address;
  uarc_irq_pkg::word_t      value;

  // Core take request, passed through by the dispatcher
  logic take;
  // Interrupt-active state owned by the dispatcher
  logic busy;

  modport source (
    output valid,
    output bus,
    output address,
    output value,
    input  take,
    input  busy
  );

  modport sink (
    input  valid,
    input  bus,
    input  address,
    input  value,
    output take,
    output busy
  );

endinterface

/* rtl/wb_irq_config.sv */
`timescale 1ns/1ps

`include "uarc_irq_macros.svh"

// Wishbone classic slave that holds the bus control registers.
// Word 0 is the bus selection mask, word 1 the interrupt enable mask and
// words 2 and up hold one handler address per bus
module wb_irq_config (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  logic [`UARC_WB_ADDR_WIDTH-1:0]   wb_adr,
  input  uarc_irq_pkg::word_t              wb_dat_w,
  output uarc_irq_pkg::word_t              wb_dat_r,
  output logic                             wb_ack,
  output uarc_irq_pkg::bus_mask_t          bus_selections,
  output uarc_irq_pkg::bus_mask_t          interrupt_enables,
  output uarc_irq_pkg::addr_table_t        interrupt_addresses
);

  localparam logic [`UARC_WB_ADDR_WIDTH-1:0] ADDR_SEL = `UARC_REG_SEL;
  localparam logic [`UARC_WB_ADDR_WIDTH-1:0] ADDR_EN = `UARC_REG_EN;
  localparam logic [`UARC_WB_ADDR_WIDTH-1:0] ADDR_TABLE_FIRST = `UARC_REG_ADDR_BASE;
  localparam logic [`UARC_WB_ADDR_WIDTH-1:0] ADDR_TABLE_END =
    `UARC_REG_ADDR_BASE + `UARC_TOTAL_BUSES;

  logic                             request;
  logic                             table_hit;
  logic [`UARC_WB_ADDR_WIDTH-1:0]   table_offset;
  uarc_irq_pkg::bus_index_t         table_index;
  uarc_irq_pkg::word_t              read_word;

  // A new transfer starts only when no ack is out, so a strobe held past
  // its ack is seen as the next request
  assign request = wb_cyc && wb_stb && !wb_ack;

  assign table_hit = (wb_adr >= ADDR_TABLE_FIRST) && (wb_adr < ADDR_TABLE_END);
  assign table_offset = wb_adr - ADDR_TABLE_FIRST;
  assign table_index = table_offset[$bits(uarc_irq_pkg::bus_index_t)-1:0];

  // Readback is zero-extended, unmapped addresses read as zero
  always_comb begin
    read_word = '0;
    if (wb_adr == ADDR_SEL) begin
      read_word = uarc_irq_pkg::word_t'(bus_selections);
    end else if (wb_adr == ADDR_EN) begin
      read_word = uarc_irq_pkg::word_t'(interrupt_enables);
    end else if (table_hit) begin
      read_word = uarc_irq_pkg::word_t'(interrupt_addresses[table_index]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      bus_selections <= '0;
      interrupt_enables <= '0;
      interrupt_addresses <= '0;
    end else begin
      wb_ack <= request;
      // Writes land on the same edge that raises the ack
      if (request && wb_we) begin
        if (wb_adr == ADDR_SEL) begin
          bus_selections <= wb_dat_w[$bits(uarc_irq_pkg::bus_mask_t)-1:0];
        end else if (wb_adr == ADDR_EN) begin
          interrupt_enables <= wb_dat_w[$bits(uarc_irq_pkg::bus_mask_t)-1:0];
        end else if (table_hit) begin
          interrupt_addresses[table_index] <=
            wb_dat_w[$bits(uarc_irq_pkg::prog_addr_t)-1:0];
        end
      end
    end
  end

  // Read data is captured with the request and is valid while ack is high
  always_ff @(posedge clk) begin
    if (request) begin
      wb_dat_r <= read_word;
    end
  end

endmodule

/* rtl/irq_arbiter.sv */
`timescale 1ns/1ps

`include "uarc_irq_macros.svh"

// Masks the receiver sends, picks the lowest pending bus and holds that
// choice with its handler address and data word until the core takes it
module irq_arbiter (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic                                            recv_mode,
  input  uarc_irq_pkg::bus_mask_t                         receiver_enables,
  input  uarc_irq_pkg::bus_mask_t                         receiver_sends,
  input  uarc_irq_pkg::word_t [`UARC_TOTAL_BUSES-1:0]     receiver_datas,
  input  uarc_irq_pkg::bus_mask_t                         bus_selections,
  input  uarc_irq_pkg::bus_mask_t                         interrupt_enables,
  input  uarc_irq_pkg::addr_table_t                       interrupt_addresses,
  irq_choice_if.source                                    choice
);

  uarc_irq_pkg::bus_mask_t    mode_mask;
  uarc_irq_pkg::bus_mask_t    masked_sends;
  uarc_irq_pkg::bus_mask_t    acked_buses;
  uarc_irq_pkg::bus_index_t   pick_bus;
  logic                       pick_on;
  logic                       taken;
  logic                       choose;

  // Receive mode listens to the selected buses, normal mode to the enabled ones
  assign mode_mask = recv_mode ? bus_selections : interrupt_enables;

  // A bus being acknowledged still has its send up for one cycle, so it is
  // kept out of the choice until the sender has dropped it
  assign masked_sends = receiver_sends & receiver_enables & mode_mask & ~acked_buses;

  // Lowest index wins
  always_comb begin
    pick_bus = '0;
    for (int i = `UARC_TOTAL_BUSES - 1; i >= 0; i--) begin
      if (masked_sends[i]) begin
        pick_bus = uarc_irq_pkg::bus_index_t'(i);
      end
    end
  end

  assign pick_on = |masked_sends;
  assign taken = choice.valid && choice.take;

  // While an interrupt is active in normal mode no new choice is made
  assign choose = !choice.valid && pick_on && (recv_mode || !choice.busy);

  always_ff @(posedge clk) begin
    if (reset) begin
      choice.valid <= 1'b0;
      acked_buses <= '0;
    end else begin
      acked_buses <= '0;
      if (taken) begin
        choice.valid <= 1'b0;
        acked_buses <= uarc_irq_pkg::bus_mask_t'(1) << choice.bus;
      end else if (choose) begin
        choice.valid <= 1'b1;
      end
    end
  end

  // The payload only moves when a fresh choice is made, so it stays put
  // for as long as valid is high
  always_ff @(posedge clk) begin
    if (choose) begin
      choice.bus <= pick_bus;
      choice.address <= interrupt_addresses[pick_bus];
      choice.value <= receiver_datas[pick_bus];
    end
  end

endmodule

/* rtl/irq_dispatch.sv */
`timescale 1ns/1ps

// Presents the held choice to the core, acknowledges the taken bus for one
// cycle and keeps the interrupt-active state until the core returns
module irq_dispatch (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       recv_mode,
  input  logic                       irq_take,
  input  logic                       irq_done,
  irq_choice_if.sink                 choice,
  output logic                       irq_valid,
  output uarc_irq_pkg::bus_index_t   irq_bus,
  output uarc_irq_pkg::prog_addr_t   irq_address,
  output uarc_irq_pkg::word_t        irq_value,
  output uarc_irq_pkg::bus_mask_t    receiver_send_acks,
  output logic                       interrupt_active
);

  logic taken;

  // The core sees the choice as it is held by the arbiter
  assign irq_valid = choice.valid;
  assign irq_bus = choice.bus;
  assign irq_address = choice.address;
  assign irq_value = choice.value;

  assign choice.take = irq_take;
  assign choice.busy = interrupt_active;

  // A take with nothing pending is ignored
  assign taken = irq_take && choice.valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      receiver_send_acks <= '0;
    end else if (taken) begin
      // One-hot acknowledge to the bus that was taken
      receiver_send_acks <= uarc_irq_pkg::bus_mask_t'(1) << choice.bus;
    end else begin
      receiver_send_acks <= '0;
    end
  end

  // Receive mode hands over the data without entering a handler, so it
  // leaves the active flag alone
  always_ff @(posedge clk) begin
    if (reset) begin
      interrupt_active <= 1'b0;
    end else if (irq_done) begin
      interrupt_active <= 1'b0;
    end else if (taken && !recv_mode) begin
      interrupt_active <= 1'b1;
    end
  end

endmodule

/* rtl/uarc_irq_unit.sv */
`timescale 1ns/1ps

`include "uarc_irq_macros.svh"

// Interrupt chooser of the UARC receiver buses as a standalone unit.
// The core programs it over Wishbone and takes interrupts over the irq ports
module uarc_irq_unit (
  input  logic                                            clk,
  input  logic                                            reset,

  // Wishbone classic slave for the control registers
  input  logic                                            wb_cyc,
  input  logic                                            wb_stb,
  input  logic                                            wb_we,
  input  logic [`UARC_WB_ADDR_WIDTH-1:0]                  wb_adr,
  input  uarc_irq_pkg::word_t                             wb_dat_w,
  output uarc_irq_pkg::word_t                             wb_dat_r,
  output logic                                            wb_ack,

  // Core side
  input  logic                                            recv_mode,
  input  logic                                            irq_take,
  input  logic                                            irq_done,
  output logic                                            irq_valid,
  output uarc_irq_pkg::bus_index_t                        irq_bus,
  output uarc_irq_pkg::prog_addr_t                        irq_address,
  output uarc_irq_pkg::word_t                             irq_value,
  output logic                                            interrupt_active,

  // Bus side
  output uarc_irq_pkg::bus_mask_t                         sender_enables,
  input  uarc_irq_pkg::bus_mask_t                         receiver_enables,
  input  uarc_irq_pkg::bus_mask_t                         receiver_sends,
  input  uarc_irq_pkg::word_t [`UARC_TOTAL_BUSES-1:0]     receiver_datas,
  output uarc_irq_pkg::bus_mask_t                         receiver_send_acks
);

  uarc_irq_pkg::bus_mask_t    bus_selections;
  uarc_irq_pkg::bus_mask_t    interrupt_enables;
  uarc_irq_pkg::addr_table_t  interrupt_addresses;

  irq_choice_if choice ();

  wb_irq_config i_config (
    .clk                 (clk),
    .reset               (reset),
    .wb_cyc              (wb_cyc),
    .wb_stb              (wb_stb),
    .wb_we               (wb_we),
    .wb_adr              (wb_adr),
    .wb_dat_w            (wb_dat_w),
    .wb_dat_r            (wb_dat_r),
    .wb_ack              (wb_ack),
    .bus_selections      (bus_selections),
    .interrupt_enables   (interrupt_enables),
    .interrupt_addresses (interrupt_addresses)
  );

  irq_arbiter i_arbiter (
    .clk                 (clk),
    .reset               (reset),
    .recv_mode           (recv_mode),
    .receiver_enables    (receiver_enables),
    .receiver_sends      (receiver_sends),
    .receiver_datas      (receiver_datas),
    .bus_selections      (bus_selections),
    .interrupt_enables   (interrupt_enables),
    .interrupt_addresses (interrupt_addresses),
    .choice              (choice.source)
  );

  irq_dispatch i_dispatch (
    .clk                 (clk),
    .reset               (reset),
    .recv_mode           (recv_mode),
    .irq_take            (irq_take),
    .irq_done            (irq_done),
    .choice              (choice.sink),
    .irq_valid           (irq_valid),
    .irq_bus             (irq_bus),
    .irq_address         (irq_address),
    .irq_value           (irq_value),
    .receiver_send_acks  (receiver_send_acks),
    .interrupt_active    (interrupt_active)
  );

  // The selected buses are also the ones this core sends on
  assign sender_enables = bus_selections;

endmodule

/* test/irq_checker.sv */
`timescale 1ns/1ps

`include "uarc_irq_macros.svh"

// Watches the DUT ports, keeps its own copy of the control registers and
// compares every response with what the interrupt rules predict
module irq_checker (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        wb_cyc,
  input  logic                                        wb_stb,
  input  logic                                        wb_we,
  input  logic [`UARC_WB_ADDR_WIDTH-1:0]              wb_adr,
  input  uarc_irq_pkg::word_t                         wb_dat_w,
  input  uarc_irq_pkg::word_t                         wb_dat_r,
  input  logic                                        wb_ack,
  input  logic                                        recv_mode,
  input  logic                                        irq_take,
  input  logic                                        irq_done,
  input  logic                                        irq_valid,
  input  uarc_irq_pkg::bus_index_t                    irq_bus,
  input  uarc_irq_pkg::prog_addr_t                    irq_address,
  input  uarc_irq_pkg::word_t                         irq_value,
  input  logic                                        interrupt_active,
  input  uarc_irq_pkg::bus_mask_t                     sender_enables,
  input  uarc_irq_pkg::word_t [`UARC_TOTAL_BUSES-1:0] receiver_datas,
  input  uarc_irq_pkg::bus_mask_t                     receiver_send_acks,
  input  int                                          test_num,
  input  int                                          exp_takes,
  input  uarc_irq_pkg::bus_index_t                    exp_bus,
  input  logic                                        test_done,
  output int                                          tests_passed,
  output int                                          tests_failed
);

  uarc_irq_pkg::word_t     regs [2**`UARC_WB_ADDR_WIDTH];
  uarc_irq_pkg::word_t     read_expect;
  uarc_irq_pkg::bus_mask_t acks_expect;
  logic                    ack_expect;
  logic                    read_pending;
  logic                    active_expect;
  int                      takes_seen;
  int                      errors;

  task automatic flag_mismatch(input string what, input uarc_irq_pkg::word_t got,
                               input uarc_irq_pkg::word_t want);
    $display("FAIL %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
    errors++;
  endtask

  // Outputs are sampled before the edge updates them, inputs were set on the falling edge
  always @(posedge clk) begin
    if (reset) begin
      regs = '{default: '0};
      ack_expect = 1'b0;
      read_pending = 1'b0;
      acks_expect = '0;
      active_expect = 1'b0;
      takes_seen = 0;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
    end else begin
      if (wb_ack !== ack_expect) begin
        flag_mismatch("wb_ack", uarc_irq_pkg::word_t'(wb_ack), uarc_irq_pkg::word_t'(ack_expect));
      end
      if (read_pending && wb_dat_r !== read_expect) begin
        flag_mismatch("wb_dat_r", wb_dat_r, read_expect);
      end
      if (sender_enables !== uarc_irq_pkg::bus_mask_t'(regs[`UARC_REG_SEL])) begin
        flag_mismatch("sender_enables", sender_enables, regs[`UARC_REG_SEL]);
      end
      if (receiver_send_acks !== acks_expect) begin
        flag_mismatch("receiver_send_acks", receiver_send_acks, acks_expect);
      end
      if (interrupt_active !== active_expect) begin
        flag_mismatch("interrupt_active", interrupt_active, active_expect);
      end
      if (irq_valid) begin
        if (exp_takes == 0) begin
          $display("FAIL %0t: irq_valid high although no send passes the masks", $time);
          errors++;
        end else if (irq_bus !== exp_bus) begin
          flag_mismatch("irq_bus", irq_bus, exp_bus);
        end else begin
          if (irq_address !==
              uarc_irq_pkg::prog_addr_t'(regs[`UARC_REG_ADDR_BASE + exp_bus])) begin
            flag_mismatch("irq_address", irq_address, regs[`UARC_REG_ADDR_BASE + exp_bus]);
          end
          if (irq_value !== receiver_datas[exp_bus]) begin
            flag_mismatch("irq_value", irq_value, receiver_datas[exp_bus]);
          end
        end
        if (interrupt_active) begin
          $display("FAIL %0t: a choice is held while interrupt_active is high", $time);
          errors++;
        end
      end

      // A request is answered by one ack on the next edge, writes land on this edge
      ack_expect = wb_cyc && wb_stb && !ack_expect;
      read_pending = ack_expect && !wb_we;
      read_expect = regs[wb_adr];
      if (ack_expect && wb_we) begin
        if (wb_adr == `UARC_REG_SEL || wb_adr == `UARC_REG_EN) begin
          regs[wb_adr] = uarc_irq_pkg::word_t'(uarc_irq_pkg::bus_mask_t'(wb_dat_w));
        end else if (wb_adr >= `UARC_REG_ADDR_BASE &&
                     wb_adr < `UARC_REG_ADDR_BASE + `UARC_TOTAL_BUSES) begin
          regs[wb_adr] = uarc_irq_pkg::word_t'(uarc_irq_pkg::prog_addr_t'(wb_dat_w));
        end
      end

      acks_expect = '0;
      if (irq_take && irq_valid) begin
        acks_expect = uarc_irq_pkg::bus_mask_t'(1) << exp_bus;
        takes_seen++;
        if (!recv_mode) begin
          active_expect = 1'b1;
        end
      end
      if (irq_done) begin
        active_expect = 1'b0;
      end

      if (test_done) begin
        if (takes_seen != exp_takes) begin
          $display("Test %0d took %0d interrupts where %0d were expected",
                   test_num, takes_seen, exp_takes);
          errors++;
        end
        if (errors == 0) begin
          $display("Test %0d passed", test_num);
          tests_passed++;
        end else begin
          $display("Test %0d failed with %0d errors", test_num, errors);
          tests_failed++;
        end
        errors = 0;
        takes_seen = 0;
      end
    end
  end

endmodule

/* test/uarc_irq_unit_tb.sv */
`timescale 1ns/1ps

`include "uarc_irq_macros.svh"

module uarc_irq_unit_tb;

  typedef logic [`UARC_WB_ADDR_WIDTH-1:0] reg_addr_t;

  // One test row, late holds sends raised after the first take and bus2 the
  // bus expected after irq_done when second is set
  typedef struct {
    uarc_irq_pkg::bus_mask_t  sel;
    uarc_irq_pkg::bus_mask_t  en;
    uarc_irq_pkg::bus_mask_t  rx_en;
    uarc_irq_pkg::bus_mask_t  sends;
    uarc_irq_pkg::bus_mask_t  late;
    logic                     mode;
    logic                     second;
    logic                     valid;
    uarc_irq_pkg::bus_index_t bus;
    uarc_irq_pkg::bus_index_t bus2;
  } row_t;

  localparam int NUM_ROWS = 8;
  localparam int WINDOW = 4;
  localparam int TIMEOUT_CYCLES = 16 + 60 * NUM_ROWS;

  // Columns: sel, en, rx_en, sends, late, mode, second, valid, bus, bus2
  row_t rows [NUM_ROWS] = '{
    '{8'h00, 8'h10, 8'hff, 8'h10, 8'h00, 1'b0, 1'b0, 1'b1, 3'd4, 3'd0},
    // Lowest of three first, the next lowest after irq_done
    '{8'h00, 8'hff, 8'hff, 8'ha4, 8'h00, 1'b0, 1'b1, 1'b1, 3'd2, 3'd5},
    // Selection does not count in normal mode
    '{8'hff, 8'hf7, 8'hff, 8'h08, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0},
    '{8'h00, 8'hff, 8'hfd, 8'h02, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0},
    // Receive mode, bus 0 is enabled but not selected
    '{8'h40, 8'h01, 8'hff, 8'h41, 8'h00, 1'b1, 1'b0, 1'b1, 3'd6, 3'd0},
    '{8'h01, 8'hff, 8'hff, 8'h02, 8'h00, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0},
    // Bus 0 sends during the handler of bus 5 and has to wait for irq_done
    '{8'h00, 8'hff, 8'hff, 8'h20, 8'h01, 1'b0, 1'b1, 1'b1, 3'd5, 3'd0},
    '{8'h00, 8'h3c, 8'hf3, 8'hff, 8'h00, 1'b0, 1'b1, 1'b1, 3'd4, 3'd5}
  };

  logic                                        clk;
  logic                                        reset;
  logic                                        wb_cyc;
  logic                                        wb_stb;
  logic                                        wb_we;
  reg_addr_t                                   wb_adr;
  uarc_irq_pkg::word_t                         wb_dat_w;
  uarc_irq_pkg::word_t                         wb_dat_r;
  logic                                        wb_ack;
  logic                                        recv_mode;
  logic                                        irq_take;
  logic                                        irq_done;
  logic                                        irq_valid;
  uarc_irq_pkg::bus_index_t                    irq_bus;
  uarc_irq_pkg::prog_addr_t                    irq_address;
  uarc_irq_pkg::word_t                         irq_value;
  logic                                        interrupt_active;
  uarc_irq_pkg::bus_mask_t                     sender_enables;
  uarc_irq_pkg::bus_mask_t                     receiver_enables;
  uarc_irq_pkg::bus_mask_t                     receiver_sends;
  uarc_irq_pkg::word_t [`UARC_TOTAL_BUSES-1:0] receiver_datas;
  uarc_irq_pkg::bus_mask_t                     receiver_send_acks;
  int                                          test_num;
  int                                          exp_takes;
  uarc_irq_pkg::bus_index_t                    exp_bus;
  logic                                        test_done;
  int                                          tests_passed;
  int                                          tests_failed;
  int                                          cycle_count = 0;

  uarc_irq_unit i_dut (.*);

  irq_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("The run timed out after %0d cycles", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  // One Wishbone classic cycle, held until the ack is seen
  task automatic bus_cycle(input logic we, input reg_addr_t adr, input uarc_irq_pkg::word_t data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = data;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    @(negedge clk);
  endtask

  task automatic write_and_read(input reg_addr_t adr, input uarc_irq_pkg::word_t data);
    bus_cycle(1'b1, adr, data);
    bus_cycle(1'b0, adr, '0);
  endtask

  task automatic pulse_done();
    irq_done = 1'b1;
    @(negedge clk);
    irq_done = 1'b0;
  endtask

  task automatic end_test();
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  // Take the held interrupt, drop the acknowledged send and return from the handler
  task automatic serve_interrupt(input uarc_irq_pkg::bus_mask_t late,
                                 input uarc_irq_pkg::bus_index_t next_bus, input logic last);
    int waited;
    waited = 0;
    irq_take = 1'b1;
    @(negedge clk);
    irq_take = 1'b0;
    while (receiver_send_acks == '0 && waited < WINDOW) begin
      @(negedge clk);
      waited++;
    end
    receiver_sends = (receiver_sends & ~receiver_send_acks) | late;
    exp_bus = next_bus;
    repeat (WINDOW) @(negedge clk);
    if (last) begin
      receiver_sends = '0;
    end
    pulse_done();
  endtask

  task automatic run_row(input int r);
    row_t row;
    int   b;
    row = rows[r];
    test_num = r + 1;
    exp_takes = int'(row.valid) + int'(row.second);
    exp_bus = row.bus;
    recv_mode = row.mode;
    receiver_enables = row.rx_en;
    for (b = 0; b < `UARC_TOTAL_BUSES; b++) begin
      receiver_datas[b] = $urandom;
    end
    write_and_read(reg_addr_t'(`UARC_REG_SEL), uarc_irq_pkg::word_t'(row.sel));
    write_and_read(reg_addr_t'(`UARC_REG_EN), uarc_irq_pkg::word_t'(row.en));
    write_and_read(reg_addr_t'(`UARC_REG_ADDR_BASE + row.bus), $urandom);
    if (row.second) begin
      write_and_read(reg_addr_t'(`UARC_REG_ADDR_BASE + row.bus2), $urandom);
    end
    receiver_sends = row.sends;
    repeat (WINDOW) @(negedge clk);
    if (row.valid) begin
      serve_interrupt(row.late, row.second ? row.bus2 : row.bus, !row.second);
    end
    if (row.second) begin
      repeat (WINDOW) @(negedge clk);
      serve_interrupt('0, row.bus2, 1'b1);
    end
    receiver_sends = '0;
    if (!row.valid) begin
      pulse_done();
    end
    end_test();
  endtask

  initial begin
    int b;
    int r;
    void'($urandom(69866));
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    recv_mode = 1'b0;
    irq_take = 1'b0;
    irq_done = 1'b0;
    receiver_enables = '0;
    receiver_sends = '0;
    receiver_datas = '0;
    test_num = 0;
    exp_takes = 0;
    exp_bus = '0;
    test_done = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Whole handler table, then a word past the map that must ignore the write
    for (b = 0; b < `UARC_TOTAL_BUSES; b++) begin
      write_and_read(reg_addr_t'(`UARC_REG_ADDR_BASE + b), $urandom);
    end
    write_and_read(reg_addr_t'(`UARC_REG_ADDR_BASE + `UARC_TOTAL_BUSES + 2), $urandom);
    end_test();

    for (r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    repeat (2) @(negedge clk);
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && tests_passed == NUM_ROWS + 1) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* uarc_irq_unit.f */
+incdir+rtl
rtl/uarc_irq_pkg.sv
rtl/irq_choice_if.sv
rtl/wb_irq_config.sv
rtl/irq_arbiter.sv
rtl/irq_dispatch.sv
rtl/uarc_irq_unit.sv
test/irq_checker.sv
test/uarc_irq_unit_tb.sv

/* Makefile */
TOP = uarc_irq_unit_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f uarc_irq_unit.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Everything OK$$"

lint:
	verilator --lint-only -Wall --timing -f uarc_irq_unit.f --top-module $(TOP)

clean:
	rm -rf obj_dir
